// File: tb.f
verilog/axiLitePkg.sv
verilog/regMapPkg.sv
verilog/axiLiteIf.sv
verilog/axiLiteWriteMaster.sv
verilog/axiLiteReadMaster.sv
verilog/axiLiteRegSlave.sv
verilog/axiLiteTop.sv
test/axiLiteTb_chk.sv
test/axiLiteTb.sv

// File: test/axiLiteTb.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteTb;

  localparam int resetCycles  = 2;
  localparam int cyclesPerCmd = 200;

  logic             aclk, arstN;
  logic             wrReq, wrReady, wrDone;
  logic             rdReq, rdReady, rdDone;
  axiLitePkg::addrT wrAddr, rdAddr;
  axiLitePkg::dataT wrData, rdData;
  axiLitePkg::strbT wrStrb;
  axiLitePkg::respT wrResp, rdResp;
  integer           seed;
  int               cycleCount = 0;
  int               issued = 0;
  axiLitePkg::dataT model [regMapPkg::regCount];  // expected contents of the register map
  axiLitePkg::respT wrRespQ [$];
  axiLitePkg::respT rdRespQ [$];
  axiLitePkg::dataT rdDataQ [$];

  axiLiteTop axiLiteTop_i (.*);

  always #20 aclk = ~aclk;

  task automatic failRun();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
    failRun();
  endtask

  // outputs are stable at the falling edge of the done cycle
  always @(negedge aclk) begin
    if (wrDone) begin
      assert (wrResp === wrRespQ[0]) else reportMismatch("wrResp", wrRespQ[0], wrResp);
      wrRespQ.delete(0);
    end
    if (rdDone) begin
      assert (rdData === rdDataQ[0]) else reportMismatch("rdData", rdDataQ[0], rdData);
      assert (rdResp === rdRespQ[0]) else reportMismatch("rdResp", rdRespQ[0], rdResp);
      rdDataQ.delete(0);
      rdRespQ.delete(0);
    end
  end

  always @(posedge aclk) begin
    cycleCount++;
    if (cycleCount > resetCycles + cyclesPerCmd * issued) begin
      $display("Timeout after %0d cycles with %0d commands issued", cycleCount, issued);
      failRun();
    end
    if (axiLiteTop_i.axiLiteTbChk_i.failCount != 0) begin
      $display("A protocol assertion in the bound checker failed");
      failRun();
    end
  end

  // starts a write, a read or both on one edge and waits for the done pulses
  task automatic issue(input logic doWr, input logic doRd, input axiLitePkg::addrT addr,
                       input axiLitePkg::dataT data = '0, input axiLitePkg::strbT strb = '0);
    int   idx;
    logic inMap;
    idx   = addr / 4;
    inMap = addr % 4 == 0 && addr < 4 * regMapPkg::regCount;
    while ((doWr && !wrReady) || (doRd && !rdReady)) @(negedge aclk);
    if (doRd) begin
      rdDataQ.push_back(inMap ? model[idx] : '0);  // taken before the write lands
      rdRespQ.push_back(inMap ? axiLitePkg::respOkay : axiLitePkg::respSlvErr);
    end
    if (doWr) begin
      wrRespQ.push_back(inMap && idx != 0 ? axiLitePkg::respOkay : axiLitePkg::respSlvErr);
      for (int b = 0; b < 4; b++)
        if (inMap && idx != 0 && strb[b]) model[idx][8*b +: 8] = data[8*b +: 8];
    end
    wrReq  = doWr;
    rdReq  = doRd;
    wrAddr = addr;
    rdAddr = addr;
    wrData = data;
    wrStrb = strb;
    issued++;
    @(negedge aclk);
    wrReq = 1'b0;
    rdReq = 1'b0;
    while ((doWr && !wrDone) || (doRd && !rdDone)) @(negedge aclk);
  endtask

  initial begin
    axiLitePkg::addrT addr;
    seed = 32'he1f4;
    {aclk, arstN, wrReq, rdReq, wrAddr, rdAddr, wrData, wrStrb} = '0;
    foreach (model[i]) model[i] = '0;
    model[0] = regMapPkg::idValue;
    repeat (resetCycles) @(negedge aclk);
    arstN = 1'b1;
    assert (wrReady && rdReady)
      else reportMismatch("{wrReady, rdReady}", 2'b11, {wrReady, rdReady});
    for (int r = 1; r < regMapPkg::regCount; r++) issue(0, 1, 4 * r);
    for (int r = 1; r < regMapPkg::regCount; r++) begin
      issue(1, 0, 4 * r, $random(seed), 4'hF);
      issue(0, 1, 4 * r);
    end
    // random strobes on random registers
    repeat (12) begin
      addr = 4 * (1 + {$random(seed)} % 7);
      issue(1, 0, addr, $random(seed), $random(seed));
      issue(0, 1, addr);
    end
    issue(0, 1, 0);
    issue(1, 0, 0, $random(seed), 4'hF);
    issue(0, 1, 0);
    repeat (8) begin
      addr = $random(seed);
      if (addr < 4 * regMapPkg::regCount) addr[1:0] = 2'b11;  // addresses in the map get misaligned
      issue(1, 0, addr, $random(seed), 4'hF);
      issue(0, 1, addr);
    end
    for (int r = 1; r < 4; r++) issue(1, 1, 4 * r, $random(seed), 4'hF);
    // a final sweep shows any register that a rejected write touched
    for (int r = 1; r < regMapPkg::regCount; r++) issue(0, 1, 4 * r);
    @(negedge aclk);
    if (wrRespQ.size() == 0 && rdDataQ.size() == 0 &&
        axiLiteTop_i.axiLiteTbChk_i.failCount == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Responses missing or a protocol assertion failed at the end of the run");
      failRun();
    end
  end

endmodule

`default_nettype wire

// File: test/axiLiteTb_chk.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteTb_chk (
  input logic aclk,
  input logic arstN,
  input logic wrReq, wrReady, wrDone,
  input logic rdReq, rdReady, rdDone,
  axiLiteIf   bus
);

  int unsigned failCount = 0;

  task automatic flagFailure(input string what);
    failCount++;
    $error("assertion failed: %s", what);
  endtask

  property validHeld(logic valid, logic ready);
    @(posedge aclk) disable iff (!arstN) valid && !ready |=> valid;
  endproperty

  // ready stays low for two cycles, then done and ready come back together
  property doneAfterThree(logic req, logic ready, logic done);
    @(posedge aclk) disable iff (!arstN)
      req && ready |=> (!ready && !done) ##1 (!ready && !done) ##1 (ready && done);
  endproperty

  awHeld: assert property (validHeld(bus.awvalid, bus.awready))
    else flagFailure("awvalid dropped before its transfer");
  wHeld: assert property (validHeld(bus.wvalid, bus.wready))
    else flagFailure("wvalid dropped before its transfer");
  bHeld: assert property (validHeld(bus.bvalid, bus.bready))
    else flagFailure("bvalid dropped before its transfer");
  arHeld: assert property (validHeld(bus.arvalid, bus.arready))
    else flagFailure("arvalid dropped before its transfer");
  rHeld: assert property (validHeld(bus.rvalid, bus.rready))
    else flagFailure("rvalid dropped before its transfer");

  wrTiming: assert property (doneAfterThree(wrReq, wrReady, wrDone))
    else flagFailure("write done not three cycles after acceptance");
  rdTiming: assert property (doneAfterThree(rdReq, rdReady, rdDone))
    else flagFailure("read done not three cycles after acceptance");

  quietAfterReset: assert property (@(posedge aclk) $rose(arstN) |->
      !bus.awvalid && !bus.wvalid && !bus.arvalid && !bus.bvalid && !bus.rvalid &&
      !wrDone && !rdDone && wrReady && rdReady)
    else flagFailure("link not idle after reset");

endmodule

bind axiLiteTop axiLiteTb_chk axiLiteTbChk_i (.*);

`default_nettype wire

// File: verilog/axiLiteIf.sv
`timescale 1ns/1ps
`default_nettype none

interface axiLiteIf (
  input logic aclk,
  input logic arstN
);

  // write address and write data
  logic             awvalid;
  logic             awready;
  axiLitePkg::addrT awaddr;
  logic             wvalid;
  logic             wready;
  axiLitePkg::dataT wdata;
  axiLitePkg::strbT wstrb;

  // write response
  logic             bvalid;
  logic             bready;
  axiLitePkg::respT bresp;

  // read address and read data
  logic             arvalid;
  logic             arready;
  axiLitePkg::addrT araddr;
  logic             rvalid;
  logic             rready;
  axiLitePkg::dataT rdata;
  axiLitePkg::respT rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp,
    input  arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  arvalid, araddr, rready,
    output awready, wready, bvalid, bresp,
    output arready, rvalid, rdata, rresp
  );

endinterface

`default_nettype wire

// File: verilog/axiLitePkg.sv
`default_nettype none

package axiLitePkg;

  // bus geometry of the AXI4-Lite link
  localparam int unsigned addrWidth = 8;
  localparam int unsigned dataWidth = 32;
  localparam int unsigned strbWidth = dataWidth / 8;

  typedef logic [addrWidth-1:0] addrT;  // byte address
  typedef logic [dataWidth-1:0] dataT;
  typedef logic [strbWidth-1:0] strbT;  // one enable per data byte

  // response codes shared by the B and R channels
  typedef logic [1:0] respT;

  localparam respT respOkay   = 2'b00;
  localparam respT respSlvErr = 2'b10;

endpackage

`default_nettype wire

// File: verilog/axiLiteReadMaster.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteReadMaster (
  input  logic             aclk,
  input  logic             arstN,
  input  logic             rdReq,
  input  axiLitePkg::addrT rdAddr,
  output logic             rdReady,
  output logic             rdDone,
  output axiLitePkg::dataT rdData,
  output axiLitePkg::respT rdResp,
  axiLiteIf.master         bus
);

  typedef enum logic [1:0] {
    idle,
    addr,
    data,
    done
  } stateT;

  stateT            state;
  logic             accept;
  axiLitePkg::addrT addrQ;
  axiLitePkg::dataT dataQ;
  axiLitePkg::respT respQ;

  assign rdReady = (state == idle) || (state == done);
  assign accept  = rdReq && rdReady;

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      state <= idle;
    end else begin
      case (state)
        idle, done: state <= accept ? addr : idle;
        addr:       if (bus.arready) state <= data;
        data:       if (bus.rvalid) state <= done;  // rready is already high here
        default:    state <= idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) addrQ <= rdAddr;
    if (state == data && bus.rvalid) begin
      dataQ <= bus.rdata;
      respQ <= bus.rresp;
    end
  end

  assign bus.arvalid = (state == addr);
  assign bus.araddr  = addrQ;
  assign bus.rready  = (state == data);

  assign rdDone = (state == done);
  assign rdData = dataQ;
  assign rdResp = respQ;

endmodule

`default_nettype wire

// File: verilog/axiLiteRegSlave.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteRegSlave (
  input logic     aclk,
  input logic     arstN,
  axiLiteIf.slave bus
);

  axiLitePkg::dataT  regs [1:regMapPkg::regCount-1];  // register 0 is a constant
  logic              bPending;
  logic              rPending;
  axiLitePkg::respT  brespQ;
  axiLitePkg::respT  rrespQ;
  axiLitePkg::dataT  rdataQ;
  logic              wrFire;
  logic              rdFire;
  logic              wrInMap;
  logic              rdInMap;
  logic              wrOk;
  regMapPkg::regIdxT wrIdx;
  regMapPkg::regIdxT rdIdx;

  // word aligned and inside the register window
  function automatic logic inMap(input axiLitePkg::addrT addr);
    return (addr[regMapPkg::offsetBits-1:0] == '0) && (addr < regMapPkg::mapBytes);
  endfunction

  assign wrInMap = inMap(bus.awaddr);
  assign rdInMap = inMap(bus.araddr);
  assign wrIdx   = bus.awaddr[regMapPkg::offsetBits +: regMapPkg::idxWidth];
  assign rdIdx   = bus.araddr[regMapPkg::offsetBits +: regMapPkg::idxWidth];
  assign wrOk    = wrInMap && (wrIdx != '0);

  // address and data are taken only as a pair, and only with the B slot free
  assign wrFire      = bus.awvalid && bus.wvalid && !bPending;
  assign bus.awready = wrFire;
  assign bus.wready  = wrFire;

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < regMapPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrFire && wrOk) begin
      for (int b = 0; b < axiLitePkg::strbWidth; b++) begin
        if (bus.wstrb[b]) regs[wrIdx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      bPending <= 1'b0;
    end else if (wrFire) begin
      bPending <= 1'b1;
    end else if (bus.bready) begin
      bPending <= 1'b0;  // bvalid is bPending, so this is the B transfer
    end
  end

  always_ff @(posedge aclk) begin
    if (wrFire) brespQ <= wrOk ? axiLitePkg::respOkay : axiLitePkg::respSlvErr;
  end

  assign bus.bvalid = bPending;
  assign bus.bresp  = brespQ;

  assign rdFire      = bus.arvalid && !rPending;
  assign bus.arready = rdFire;

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      rPending <= 1'b0;
    end else if (rdFire) begin
      rPending <= 1'b1;
    end else if (bus.rready) begin
      rPending <= 1'b0;
    end
  end

  // sampled on the same edge as a write, so a colliding read sees the old value
  always_ff @(posedge aclk) begin
    if (rdFire) begin
      if (!rdInMap) begin
        rdataQ <= '0;
        rrespQ <= axiLitePkg::respSlvErr;
      end else if (rdIdx == '0) begin
        rdataQ <= regMapPkg::idValue;
        rrespQ <= axiLitePkg::respOkay;
      end else begin
        rdataQ <= regs[rdIdx];
        rrespQ <= axiLitePkg::respOkay;
      end
    end
  end

  assign bus.rvalid = rPending;
  assign bus.rdata  = rdataQ;
  assign bus.rresp  = rrespQ;

endmodule

`default_nettype wire

// File: verilog/axiLiteTop.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteTop (
  input  logic             aclk,
  input  logic             arstN,
  input  logic             wrReq,
  input  axiLitePkg::addrT wrAddr,
  input  axiLitePkg::dataT wrData,
  input  axiLitePkg::strbT wrStrb,
  output logic             wrReady,
  output logic             wrDone,
  output axiLitePkg::respT wrResp,
  input  logic             rdReq,
  input  axiLitePkg::addrT rdAddr,
  output logic             rdReady,
  output logic             rdDone,
  output axiLitePkg::dataT rdData,
  output axiLitePkg::respT rdResp
);

  axiLiteIf bus (
    .aclk  (aclk),
    .arstN (arstN)
  );

  // both masters share one link, each driving only its own channels
  axiLiteWriteMaster writeMaster (
    .aclk    (aclk),
    .arstN   (arstN),
    .wrReq   (wrReq),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .wrStrb  (wrStrb),
    .wrReady (wrReady),
    .wrDone  (wrDone),
    .wrResp  (wrResp),
    .bus     (bus.master)
  );

  axiLiteReadMaster readMaster (
    .aclk    (aclk),
    .arstN   (arstN),
    .rdReq   (rdReq),
    .rdAddr  (rdAddr),
    .rdReady (rdReady),
    .rdDone  (rdDone),
    .rdData  (rdData),
    .rdResp  (rdResp),
    .bus     (bus.master)
  );

  axiLiteRegSlave regSlave (
    .aclk  (aclk),
    .arstN (arstN),
    .bus   (bus.slave)
  );

endmodule

`default_nettype wire

// File: verilog/axiLiteWriteMaster.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteWriteMaster (
  input  logic             aclk,
  input  logic             arstN,
  input  logic             wrReq,
  input  axiLitePkg::addrT wrAddr,
  input  axiLitePkg::dataT wrData,
  input  axiLitePkg::strbT wrStrb,
  output logic             wrReady,
  output logic             wrDone,
  output axiLitePkg::respT wrResp,
  axiLiteIf.master         bus
);

  typedef enum logic [1:0] {
    idle,
    addrData,
    resp,
    done
  } stateT;

  stateT            state;
  logic             accept;
  axiLitePkg::addrT addrQ;
  axiLitePkg::dataT dataQ;
  axiLitePkg::strbT strbQ;
  axiLitePkg::respT respQ;

  assign wrReady = (state == idle) || (state == done);  // a new command may follow the done cycle
  assign accept  = wrReq && wrReady;

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      state <= idle;
    end else begin
      case (state)
        idle, done: begin
          state <= accept ? addrData : idle;
        end
        addrData: begin
          if (bus.awready && bus.wready) state <= resp;
        end
        resp: begin
          if (bus.bvalid) state <= done;
        end
        default: state <= idle;
      endcase
    end
  end

  // command is held here so the bus payload stays stable while valid is up
  always_ff @(posedge aclk) begin
    if (accept) begin
      addrQ <= wrAddr;
      dataQ <= wrData;
      strbQ <= wrStrb;
    end
    if (state == resp && bus.bvalid) respQ <= bus.bresp;
  end

  assign bus.awvalid = (state == addrData);
  assign bus.wvalid  = (state == addrData);  // address and data go out together
  assign bus.awaddr  = addrQ;
  assign bus.wdata   = dataQ;
  assign bus.wstrb   = strbQ;
  assign bus.bready  = (state == resp);

  assign wrDone = (state == done);
  assign wrResp = respQ;

endmodule

`default_nettype wire

// File: verilog/regMapPkg.sv
`default_nettype none

package regMapPkg;

  localparam int unsigned regCount   = 8;
  localparam int unsigned idxWidth   = $clog2(regCount);
  localparam int unsigned offsetBits = 2;  // registers are word aligned with four bytes each
  localparam int unsigned mapBytes   = regCount * 4;

  typedef logic [idxWidth-1:0] regIdxT;

  // register 0 reads back this word so software can identify the block
  localparam axiLitePkg::dataT idValue = 32'hA4E1_0001;

endpackage

`default_nettype wire
